/* Bender.yml */
package:
  name: accel_blit

sources:
  - include_dirs:
      - hw
    files:
      - hw/blit_pkg.sv
      - hw/csr_async_write.sv
      - hw/csr_async_read.sv
      - hw/blit_csr.sv
      - hw/blit_engine.sv
      - hw/accel_blit.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/fsab_mem_model.sv
      - verif/tb_accel_blit.sv

/* hw/accel_blit.sv */
// Top level of the blitter, register block on SPAM and copy engine on FSAB
`timescale 1ns/1ps
`include "blit_config.svh"

module accel_blit (
	input  logic                         fsabi_clk,
	input  logic                         fsabi_rst_b,
	input  logic                         cclk,
	input  logic                         cclk_rst_b,
	output logic                         fsabo_valid,
	output blit_pkg::fsab_mode_t         fsabo_mode,
	output logic [`BLIT_DID_W-1:0]       fsabo_did,
	output logic [`BLIT_DID_W-1:0]       fsabo_subdid,
	output logic [`BLIT_ADDR_W-1:0]      fsabo_addr,
	output logic [`BLIT_LEN_W-1:0]       fsabo_len,
	output logic [`BLIT_DATA_W-1:0]      fsabo_data,
	output logic [`BLIT_MASK_W-1:0]      fsabo_mask,
	input  logic                         fsabo_credit,
	input  logic                         fsabi_valid,
	input  logic [`BLIT_DID_W-1:0]       fsabi_did,
	input  logic [`BLIT_DID_W-1:0]       fsabi_subdid,
	input  logic [`BLIT_DATA_W-1:0]      fsabi_data,
	input  logic                         spamo_valid,
	input  logic                         spamo_r_nw,
	input  logic [`BLIT_DID_W-1:0]       spamo_did,
	input  logic [`BLIT_SPAM_ADDR_W-1:0] spamo_addr,
	input  logic [`BLIT_SPAM_DATA_W-1:0] spamo_data,
	output logic                         spami_busy_b,
	output logic [`BLIT_SPAM_DATA_W-1:0] spami_data
);
	// Register values in the fsabi_clk domain
	logic                   rdaddr_strobe;
	logic [`BLIT_REG_W-1:0] rdaddr_value;
	logic                   rdlen_strobe;
	logic [`BLIT_REG_W-1:0] rdlen_value;
	logic                   wraddr_strobe;
	logic [`BLIT_REG_W-1:0] wraddr_value;
	logic                   wrrowl_strobe;
	logic [`BLIT_REG_W-1:0] wrrowl_value;
	logic [`BLIT_REG_W-1:0] wrrows_value;
	logic                   wrdone_strobe;
	logic [`BLIT_REG_W-1:0] wrdone_value;
	logic [`BLIT_REG_W-1:0] wr_done_count;

	blit_csr u_csr (.*);

	blit_engine u_engine (.*);

endmodule

/* hw/blit_config.svh */
// Bus widths, IDs and the register window shared by the blitter RTL and testbench
`ifndef BLIT_CONFIG_SVH
`define BLIT_CONFIG_SVH

// System memory bus
`define BLIT_ADDR_W        31
`define BLIT_DATA_W        64
`define BLIT_MASK_W        8
`define BLIT_LEN_W         4
`define BLIT_DID_W         4
`define BLIT_BURST_WORDS   8
`define BLIT_FSAB_CREDITS  4
`define BLIT_CREDIT_W      3
`define BLIT_FSAB_DID      4'h3
`define BLIT_FSAB_SUBDID   4'h1

// Peripheral register bus
`define BLIT_SPAM_DID      4'h2
`define BLIT_SPAM_ADDR_W   24
`define BLIT_SPAM_DATA_W   32
`define BLIT_SPAM_PFX      24'h100000
`define BLIT_SPAM_MASK     24'hF00000
`define BLIT_REG_W         31

`endif

/* hw/blit_csr.sv */
// SPAM register block of the blitter, one clock crossing per register
`timescale 1ns/1ps
`include "blit_config.svh"

module blit_csr (
	input  logic                         cclk,
	input  logic                         cclk_rst_b,
	input  logic                         fsabi_clk,
	input  logic                         fsabi_rst_b,
	input  logic                         spamo_valid,
	input  logic                         spamo_r_nw,
	input  logic [`BLIT_DID_W-1:0]       spamo_did,
	input  logic [`BLIT_SPAM_ADDR_W-1:0] spamo_addr,
	input  logic [`BLIT_SPAM_DATA_W-1:0] spamo_data,
	output logic                         spami_busy_b,
	output logic [`BLIT_SPAM_DATA_W-1:0] spami_data,
	input  logic [`BLIT_REG_W-1:0]       wr_done_count,
	output logic                         rdaddr_strobe,
	output logic [`BLIT_REG_W-1:0]       rdaddr_value,
	output logic                         rdlen_strobe,
	output logic [`BLIT_REG_W-1:0]       rdlen_value,
	output logic                         wraddr_strobe,
	output logic [`BLIT_REG_W-1:0]       wraddr_value,
	output logic                         wrrowl_strobe,
	output logic [`BLIT_REG_W-1:0]       wrrowl_value,
	output logic [`BLIT_REG_W-1:0]       wrrows_value,
	output logic                         wrdone_strobe,
	output logic [`BLIT_REG_W-1:0]       wrdone_value
);
	localparam blit_pkg::blit_reg_t WR_REGS [6] = '{
		blit_pkg::REG_RDADDR, blit_pkg::REG_RDLEN, blit_pkg::REG_WRADDR,
		blit_pkg::REG_WRROWL, blit_pkg::REG_WRROWS, blit_pkg::REG_WRDONE
	};

	blit_pkg::blit_reg_t     reg_sel;
	logic                    win_hit;
	logic                    acc_active;
	logic                    acc_start;
	logic                    wr_start;
	logic                    rd_start;
	logic                    reg_known;
	logic [5:0]              wr_hit;
	logic [5:0]              wr_strobe;
	logic [5:0]              wr_done;
	logic [`BLIT_REG_W-1:0]  wr_value [6];
	logic                    rd_done;
	logic                    miss_done;
	logic [`BLIT_REG_W-1:0]  rd_data_cclk;

	assign reg_sel = blit_pkg::blit_reg_t'(spamo_addr[4:0]);
	assign win_hit = (spamo_did == `BLIT_SPAM_DID) &&
	                 ((spamo_addr & `BLIT_SPAM_MASK) == `BLIT_SPAM_PFX);
	// One start per access, the master holds valid until busy_b
	assign acc_start = spamo_valid && win_hit && !acc_active;
	assign wr_start = acc_start && !spamo_r_nw;
	assign rd_start = acc_start && spamo_r_nw;
	assign reg_known = spamo_r_nw ? (reg_sel == blit_pkg::REG_WRDONE) : |wr_hit;

	for (genvar i = 0; i < 6; i++) begin : g_wr
		assign wr_hit[i] = (reg_sel == WR_REGS[i]);

		csr_async_write #(
			.WIDTH       (`BLIT_REG_W),
			.RESET_VALUE ('0)
		) u_wr (
			.cclk           (cclk),
			.cclk_rst_b     (cclk_rst_b),
			.fsabi_clk      (fsabi_clk),
			.fsabi_rst_b    (fsabi_rst_b),
			.wr_strobe_cclk (wr_start && wr_hit[i]),
			.wr_data_cclk   (spamo_data[`BLIT_REG_W-1:0]),
			.wr_strobe      (wr_strobe[i]),
			.wr_data        (wr_value[i]),
			.wr_done_cclk   (wr_done[i])
		);
	end

	csr_async_read #(
		.WIDTH (`BLIT_REG_W)
	) u_rd_wrdone (
		.cclk           (cclk),
		.cclk_rst_b     (cclk_rst_b),
		.fsabi_clk      (fsabi_clk),
		.fsabi_rst_b    (fsabi_rst_b),
		.rd_strobe_cclk (rd_start && (reg_sel == blit_pkg::REG_WRDONE)),
		.rd_data        (wr_done_count),
		.rd_data_cclk   (rd_data_cclk),
		.rd_done_cclk   (rd_done)
	);

	assign rdaddr_strobe = wr_strobe[0];
	assign rdaddr_value  = wr_value[0];
	assign rdlen_strobe  = wr_strobe[1];
	assign rdlen_value   = wr_value[1];
	assign wraddr_strobe = wr_strobe[2];
	assign wraddr_value  = wr_value[2];
	assign wrrowl_strobe = wr_strobe[3];
	assign wrrowl_value  = wr_value[3];
	assign wrrows_value  = wr_value[4];
	assign wrdone_strobe = wr_strobe[5];
	assign wrdone_value  = wr_value[5];

	always_ff @(posedge cclk or negedge cclk_rst_b) begin
		if (!cclk_rst_b) begin
			acc_active <= 1'b0;
			miss_done <= 1'b0;
			spami_busy_b <= 1'b0;
			spami_data <= '0;
		end else begin
			if (acc_start)
				acc_active <= 1'b1;
			else if (spami_busy_b)
				acc_active <= 1'b0;
			// Unmapped accesses complete at once and read as zero
			miss_done <= acc_start && !reg_known;
			spami_busy_b <= |wr_done || rd_done || miss_done;
			spami_data <= rd_done ?
				{{(`BLIT_SPAM_DATA_W - `BLIT_REG_W){1'b0}}, rd_data_cclk} : '0;
		end
	end

	one_done: assert property (@(posedge cclk) disable iff (!cclk_rst_b)
		$onehot0({wr_done, rd_done, miss_done}))
		else $error("blit_csr: more than one done pulse in a cycle");

endmodule

/* hw/blit_engine.sv */
// Blitter copy engine inside accel_blit that reads FSAB bursts and writes them back along a strided cursor
`timescale 1ns/1ps
`include "blit_config.svh"

module blit_engine (
	input  logic                     fsabi_clk,
	input  logic                     fsabi_rst_b,
	output logic                     fsabo_valid,
	output blit_pkg::fsab_mode_t     fsabo_mode,
	output logic [`BLIT_DID_W-1:0]   fsabo_did,
	output logic [`BLIT_DID_W-1:0]   fsabo_subdid,
	output logic [`BLIT_ADDR_W-1:0]  fsabo_addr,
	output logic [`BLIT_LEN_W-1:0]   fsabo_len,
	output logic [`BLIT_DATA_W-1:0]  fsabo_data,
	output logic [`BLIT_MASK_W-1:0]  fsabo_mask,
	input  logic                     fsabo_credit,
	input  logic                     fsabi_valid,
	input  logic [`BLIT_DID_W-1:0]   fsabi_did,
	input  logic [`BLIT_DID_W-1:0]   fsabi_subdid,
	input  logic [`BLIT_DATA_W-1:0]  fsabi_data,
	input  logic                     rdaddr_strobe,
	input  logic [`BLIT_REG_W-1:0]   rdaddr_value,
	input  logic                     rdlen_strobe,
	input  logic [`BLIT_REG_W-1:0]   rdlen_value,
	input  logic                     wraddr_strobe,
	input  logic [`BLIT_REG_W-1:0]   wraddr_value,
	input  logic                     wrrowl_strobe,
	input  logic [`BLIT_REG_W-1:0]   wrrowl_value,
	input  logic [`BLIT_REG_W-1:0]   wrrows_value,
	input  logic                     wrdone_strobe,
	input  logic [`BLIT_REG_W-1:0]   wrdone_value,
	output logic [`BLIT_REG_W-1:0]   wr_done_count
);
	localparam int IDX_W = $clog2(`BLIT_BURST_WORDS);
	localparam logic [`BLIT_ADDR_W-1:0] BURST_BYTES =
		`BLIT_ADDR_W'(`BLIT_BURST_WORDS * `BLIT_DATA_W / 8);
	localparam logic [`BLIT_LEN_W-1:0] BURST_LEN = `BLIT_LEN_W'(`BLIT_BURST_WORDS);

	logic [`BLIT_CREDIT_W-1:0] credit_cnt;
	logic                      trans_start;
	logic                      trans_is_read;
	logic                      beat_hit;
	logic                      burst_end;
	logic [`BLIT_LEN_W-1:0]    words_rem;
	logic [`BLIT_ADDR_W-1:0]   rdaddr;
	logic [`BLIT_REG_W-1:0]    rdlen;
	logic [`BLIT_ADDR_W-1:0]   wraddr_cur;
	logic [`BLIT_ADDR_W-1:0]   wraddr_row;
	logic [`BLIT_REG_W-1:0]    rowl_rem;
	logic [`BLIT_DATA_W-1:0]   wbuf [`BLIT_BURST_WORDS];
	logic [IDX_W-1:0]          send_idx;
	logic [`BLIT_DATA_W-1:0]   send_word;

	assign fsabo_did = `BLIT_FSAB_DID;
	assign fsabo_subdid = `BLIT_FSAB_SUBDID;
	assign fsabo_len = BURST_LEN;

	assign trans_start = !rdaddr_strobe && !rdlen_strobe && (credit_cnt != 0) &&
	                     (words_rem == 0) && (!trans_is_read || (rdlen != 0));
	assign beat_hit = fsabi_valid && (fsabi_did == `BLIT_FSAB_DID) &&
	                  (fsabi_subdid == `BLIT_FSAB_SUBDID) && trans_is_read && (words_rem != 0);
	assign burst_end = !trans_is_read && (words_rem == 1);

	// A zero count wraps to the slot holding the first returned word
	assign send_idx = IDX_W'(words_rem - 1'b1);
	assign send_word = wbuf[send_idx];

	always_ff @(posedge fsabi_clk or negedge fsabi_rst_b) begin
		if (!fsabi_rst_b) begin
			credit_cnt <= `BLIT_FSAB_CREDITS;
			trans_is_read <= 1'b1;
			words_rem <= '0;
			rdaddr <= '0;
			rdlen <= '0;
			wraddr_cur <= '0;
			wraddr_row <= '0;
			rowl_rem <= '0;
			wr_done_count <= '0;
			fsabo_valid <= 1'b0;
		end else begin
			credit_cnt <= credit_cnt + `BLIT_CREDIT_W'(fsabo_credit) -
			              `BLIT_CREDIT_W'(trans_start);

			if (rdaddr_strobe)
				rdaddr <= rdaddr_value;
			else if (trans_start && trans_is_read)
				rdaddr <= rdaddr + BURST_BYTES;

			if (rdlen_strobe)
				rdlen <= rdlen_value;
			else if (trans_start && trans_is_read)
				rdlen <= rdlen - 1'b1;

			if (trans_start)
				words_rem <= trans_is_read ? BURST_LEN : BURST_LEN - 1'b1;
			else if (beat_hit || (!trans_is_read && (words_rem != 0)))
				words_rem <= words_rem - 1'b1;

			if (beat_hit && (words_rem == 1))
				trans_is_read <= 1'b0;
			else if (burst_end)
				trans_is_read <= 1'b1;

			if (wraddr_strobe || wrrowl_strobe || wrdone_strobe) begin
				wraddr_cur <= wraddr_value;
				wraddr_row <= wraddr_value;
				rowl_rem <= wrrowl_value - 1'b1;
				wr_done_count <= wrdone_value;
			end else if (burst_end) begin
				if (rowl_rem == 0) begin
					// Row complete so jump to the next row start
					rowl_rem <= wrrowl_value - 1'b1;
					wraddr_row <= wraddr_row + wrrows_value;
					wraddr_cur <= wraddr_row + wrrows_value;
				end else begin
					rowl_rem <= rowl_rem - 1'b1;
					wraddr_cur <= wraddr_cur + BURST_BYTES;
				end
				wr_done_count <= wr_done_count + 1'b1;
			end

			fsabo_valid <= trans_start || (!trans_is_read && (words_rem != 0));
		end
	end

	always_ff @(posedge fsabi_clk) begin
		if (beat_hit)
			wbuf[IDX_W'(words_rem - 1'b1)] <= fsabi_data;
		fsabo_mode <= trans_is_read ? blit_pkg::FSAB_READ : blit_pkg::FSAB_WRITE;
		fsabo_addr <= trans_is_read ? rdaddr : wraddr_cur;
		fsabo_data <= send_word;
		// Transparency key in bit 0 of each half
		fsabo_mask <= {{(`BLIT_MASK_W / 2){send_word[`BLIT_DATA_W / 2]}},
		               {(`BLIT_MASK_W / 2){send_word[0]}}};
	end

	credit_range: assert property (@(posedge fsabi_clk) disable iff (!fsabi_rst_b)
		credit_cnt <= `BLIT_FSAB_CREDITS)
		else $error("blit_engine: credit count out of range");

	read_req_once: assert property (@(posedge fsabi_clk) disable iff (!fsabi_rst_b)
		fsabo_valid && (fsabo_mode == blit_pkg::FSAB_READ) |->
		$past(trans_start && trans_is_read) ##1 !fsabo_valid)
		else $error("blit_engine: valid outside the read request cycle");

endmodule

/* hw/blit_pkg.sv */
// Bus request and register select types for the blitter, used by scoped name
package blit_pkg;

	// Kind of FSAB request
	typedef enum logic {
		FSAB_READ  = 1'b0,
		FSAB_WRITE = 1'b1
	} fsab_mode_t;

	// Register select in the five low SPAM address bits
	typedef enum logic [4:0] {
		REG_RDADDR = 5'h00,
		REG_RDLEN  = 5'h04,
		REG_WRADDR = 5'h08,
		REG_WRROWL = 5'h0C,
		REG_WRROWS = 5'h10,
		REG_WRDONE = 5'h14
	} blit_reg_t;

endpackage

/* hw/csr_async_read.sv */
// Samples a fsabi_clk value on a cclk read request and hands it back with a done pulse
`timescale 1ns/1ps

module csr_async_read #(
	parameter int WIDTH = 31
) (
	input  logic             cclk,
	input  logic             cclk_rst_b,
	input  logic             fsabi_clk,
	input  logic             fsabi_rst_b,
	input  logic             rd_strobe_cclk,
	input  logic [WIDTH-1:0] rd_data,
	output logic [WIDTH-1:0] rd_data_cclk,
	output logic             rd_done_cclk
);
	logic [WIDTH-1:0] sample_hold;
	logic             req_tgl;
	logic             pending;
	logic [1:0]       ack_sync;
	logic             ack_seen;
	logic             ack_edge;
	logic [1:0]       req_sync;
	logic             req_seen;
	logic             req_edge;
	logic             ack_tgl;

	assign ack_edge = ack_sync[1] ^ ack_seen;
	assign req_edge = req_sync[1] ^ req_seen;

	always_ff @(posedge cclk or negedge cclk_rst_b) begin
		if (!cclk_rst_b) begin
			req_tgl <= 1'b0;
			pending <= 1'b0;
			ack_sync <= 2'b00;
			ack_seen <= 1'b0;
			rd_done_cclk <= 1'b0;
		end else begin
			ack_sync <= {ack_sync[0], ack_tgl};
			ack_seen <= ack_sync[1];
			rd_done_cclk <= ack_edge;
			if (rd_strobe_cclk && !pending) begin
				req_tgl <= ~req_tgl;
				pending <= 1'b1;
			end else if (ack_edge) begin
				pending <= 1'b0;
			end
		end
	end

	// Sample is frozen in fsabi_clk until the next request
	always_ff @(posedge cclk) begin
		if (ack_edge)
			rd_data_cclk <= sample_hold;
	end

	always_ff @(posedge fsabi_clk or negedge fsabi_rst_b) begin
		if (!fsabi_rst_b) begin
			req_sync <= 2'b00;
			req_seen <= 1'b0;
			ack_tgl <= 1'b0;
		end else begin
			req_sync <= {req_sync[0], req_tgl};
			req_seen <= req_sync[1];
			if (req_edge)
				ack_tgl <= ~ack_tgl;
		end
	end

	always_ff @(posedge fsabi_clk) begin
		if (req_edge)
			sample_hold <= rd_data;
	end

	rd_while_pending: assert property (@(posedge cclk) disable iff (!cclk_rst_b)
		rd_strobe_cclk |-> !pending)
		else $error("csr_async_read: new read while one is pending");

endmodule

/* hw/csr_async_write.sv */
// Moves one register write from cclk into fsabi_clk and returns a done pulse to cclk
`timescale 1ns/1ps

module csr_async_write #(
	parameter int WIDTH = 31,
	parameter logic [WIDTH-1:0] RESET_VALUE = '0
) (
	input  logic             cclk,
	input  logic             cclk_rst_b,
	input  logic             fsabi_clk,
	input  logic             fsabi_rst_b,
	input  logic             wr_strobe_cclk,
	input  logic [WIDTH-1:0] wr_data_cclk,
	output logic             wr_strobe,
	output logic [WIDTH-1:0] wr_data,
	output logic             wr_done_cclk
);
	logic [WIDTH-1:0] data_hold;
	logic             req_tgl;
	logic             pending;
	logic [1:0]       ack_sync;
	logic             ack_seen;
	logic             ack_edge;
	logic [1:0]       req_sync;
	logic             req_seen;
	logic             req_edge;
	logic             ack_tgl;

	assign ack_edge = ack_sync[1] ^ ack_seen;
	assign req_edge = req_sync[1] ^ req_seen;

	always_ff @(posedge cclk or negedge cclk_rst_b) begin
		if (!cclk_rst_b) begin
			req_tgl <= 1'b0;
			pending <= 1'b0;
			ack_sync <= 2'b00;
			ack_seen <= 1'b0;
			wr_done_cclk <= 1'b0;
		end else begin
			ack_sync <= {ack_sync[0], ack_tgl};
			ack_seen <= ack_sync[1];
			wr_done_cclk <= ack_edge;
			if (wr_strobe_cclk && !pending) begin
				req_tgl <= ~req_tgl;
				pending <= 1'b1;
			end else if (ack_edge) begin
				pending <= 1'b0;
			end
		end
	end

	// Stays put until the acknowledge comes back
	always_ff @(posedge cclk) begin
		if (wr_strobe_cclk && !pending)
			data_hold <= wr_data_cclk;
	end

	always_ff @(posedge fsabi_clk or negedge fsabi_rst_b) begin
		if (!fsabi_rst_b) begin
			req_sync <= 2'b00;
			req_seen <= 1'b0;
			ack_tgl <= 1'b0;
			wr_strobe <= 1'b0;
			wr_data <= RESET_VALUE;
		end else begin
			req_sync <= {req_sync[0], req_tgl};
			req_seen <= req_sync[1];
			wr_strobe <= req_edge;
			if (req_edge) begin
				wr_data <= data_hold;
				ack_tgl <= ~ack_tgl;
			end
		end
	end

	wr_while_pending: assert property (@(posedge cclk) disable iff (!cclk_rst_b)
		wr_strobe_cclk |-> !pending)
		else $error("csr_async_write: new write while one is pending");

endmodule

/* verif/fsab_mem_model.sv */
// Behavioral FSAB memory for the blitter testbench, answers reads, logs write beats, returns credits
`timescale 1ns/1ps
`include "blit_config.svh"

module fsab_mem_model #(
	parameter int MEM_WORDS = 1024,
	parameter int LOG_BEATS = 512,
	parameter int RD_DELAY  = 4
) (
	input  logic                    fsabi_clk,
	input  logic                    fsabi_rst_b,
	input  logic                    hold,
	input  logic                    fsabo_valid,
	input  blit_pkg::fsab_mode_t    fsabo_mode,
	input  logic [`BLIT_ADDR_W-1:0] fsabo_addr,
	input  logic [`BLIT_DATA_W-1:0] fsabo_data,
	input  logic [`BLIT_MASK_W-1:0] fsabo_mask,
	output logic                    fsabo_credit,
	output logic                    fsabi_valid,
	output logic [`BLIT_DID_W-1:0]  fsabi_did,
	output logic [`BLIT_DID_W-1:0]  fsabi_subdid,
	output logic [`BLIT_DATA_W-1:0] fsabi_data
);
	logic [`BLIT_DATA_W-1:0] mem [MEM_WORDS];
	logic [`BLIT_ADDR_W-1:0] log_addr [LOG_BEATS];
	logic [`BLIT_DATA_W-1:0] log_data [LOG_BEATS];
	logic [`BLIT_MASK_W-1:0] log_mask [LOG_BEATS];
	int                      log_cnt;
	int                      owed;
	logic                    rd_busy;
	int                      rd_wait;
	int                      rd_beat;
	int                      rd_base;
	int                      wr_beat;
	logic                    rd_last;
	logic                    wr_last;
	logic                    give;

	assign fsabi_did = `BLIT_FSAB_DID;
	assign fsabi_subdid = `BLIT_FSAB_SUBDID;

	assign rd_last = rd_busy && (rd_wait == 0) && (rd_beat == `BLIT_BURST_WORDS - 1);
	assign wr_last = fsabo_valid && (fsabo_mode == blit_pkg::FSAB_WRITE) &&
	                 (wr_beat == `BLIT_BURST_WORDS - 1);
	// Credits pile up while held, then go back one per cycle
	assign give = (owed != 0) && !hold;

	always @(posedge fsabi_clk or negedge fsabi_rst_b) begin
		if (!fsabi_rst_b) begin
			fsabo_credit <= 1'b0;
			fsabi_valid <= 1'b0;
			fsabi_data <= '0;
			log_cnt <= 0;
			owed <= 0;
			rd_busy <= 1'b0;
			rd_wait <= 0;
			rd_beat <= 0;
			rd_base <= 0;
			wr_beat <= 0;
		end else begin
			fsabi_valid <= 1'b0;
			fsabo_credit <= give;
			owed <= owed + int'(rd_last) + int'(wr_last) - int'(give);
			if (fsabo_valid && (fsabo_mode == blit_pkg::FSAB_READ)) begin
				rd_busy <= 1'b1;
				rd_wait <= RD_DELAY;
				rd_beat <= 0;
				rd_base <= int'(fsabo_addr >> 3);
			end else if (rd_busy && (rd_wait != 0)) begin
				rd_wait <= rd_wait - 1;
			end else if (rd_busy) begin
				fsabi_valid <= 1'b1;
				fsabi_data <= mem[(rd_base + rd_beat) % MEM_WORDS];
				rd_beat <= rd_beat + 1;
				rd_busy <= !rd_last;
			end
			if (fsabo_valid && (fsabo_mode == blit_pkg::FSAB_WRITE)) begin
				log_addr[log_cnt] <= fsabo_addr;
				log_data[log_cnt] <= fsabo_data;
				log_mask[log_cnt] <= fsabo_mask;
				log_cnt <= log_cnt + 1;
				wr_beat <= wr_last ? 0 : wr_beat + 1;
			end
		end
	end

endmodule

/* verif/tb_accel_blit.sv */
// Directed testbench that programs the blitter over SPAM and checks its FSAB write traffic
`timescale 1ns/1ps
`include "blit_config.svh"

module tb_accel_blit;
	localparam int MEM_WORDS = 1024;
	// One read and one write burst for every copied burst in all tests
	localparam int TOTAL_BURSTS = 2 * (3 + 6 + 8 + 2);
	localparam int CYCLE_LIMIT = 40 * TOTAL_BURSTS + 2000;
	localparam int WAIT_LIMIT = 1500;

	logic                         fsabi_clk;
	logic                         fsabi_rst_b;
	logic                         cclk;
	logic                         cclk_rst_b;
	logic                         fsabo_valid;
	blit_pkg::fsab_mode_t         fsabo_mode;
	logic [`BLIT_DID_W-1:0]       fsabo_did;
	logic [`BLIT_DID_W-1:0]       fsabo_subdid;
	logic [`BLIT_ADDR_W-1:0]      fsabo_addr;
	logic [`BLIT_LEN_W-1:0]       fsabo_len;
	logic [`BLIT_DATA_W-1:0]      fsabo_data;
	logic [`BLIT_MASK_W-1:0]      fsabo_mask;
	logic                         fsabo_credit;
	logic                         fsabi_valid;
	logic [`BLIT_DID_W-1:0]       fsabi_did;
	logic [`BLIT_DID_W-1:0]       fsabi_subdid;
	logic [`BLIT_DATA_W-1:0]      fsabi_data;
	logic                         spamo_valid;
	logic                         spamo_r_nw;
	logic [`BLIT_DID_W-1:0]       spamo_did;
	logic [`BLIT_SPAM_ADDR_W-1:0] spamo_addr;
	logic [`BLIT_SPAM_DATA_W-1:0] spamo_data;
	logic                         spami_busy_b;
	logic [`BLIT_SPAM_DATA_W-1:0] spami_data;
	logic                         mem_hold;
	logic [`BLIT_DATA_W-1:0]      ref_mem [MEM_WORDS];
	int                           seed;
	int                           errors = 0;
	int                           checks = 0;
	int                           cycles = 0;
	int                           started = 0;
	int                           returned = 0;
	int                           mon_beat = 0;

	accel_blit DUT (.*);

	fsab_mem_model u_mem (
		.fsabi_clk    (fsabi_clk),
		.fsabi_rst_b  (fsabi_rst_b),
		.hold         (mem_hold),
		.fsabo_valid  (fsabo_valid),
		.fsabo_mode   (fsabo_mode),
		.fsabo_addr   (fsabo_addr),
		.fsabo_data   (fsabo_data),
		.fsabo_mask   (fsabo_mask),
		.fsabo_credit (fsabo_credit),
		.fsabi_valid  (fsabi_valid),
		.fsabi_did    (fsabi_did),
		.fsabi_subdid (fsabi_subdid),
		.fsabi_data   (fsabi_data)
	);

	initial begin
		fsabi_clk = 1'b0;
		forever #10 fsabi_clk = ~fsabi_clk;
	end

	initial begin
		cclk = 1'b0;
		forever #15 cclk = ~cclk;
	end

	task automatic report_error(input string msg);
		errors++;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	task automatic compare(input string name, input logic [63:0] expected,
	                       input logic [63:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("[FAIL] %0t %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
		end
	endtask

	always @(posedge fsabi_clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles with %0d errors", cycles, errors);
			$display("tests failed");
			$finish;
		end
	end

	// Bursts started but not yet paid back by a credit pulse
	always @(posedge fsabi_clk) begin
		if (fsabi_rst_b) begin
			if (fsabo_credit)
				returned = returned + 1;
			if (fsabo_valid && (fsabo_mode == blit_pkg::FSAB_READ))
				started = started + 1;
			if (fsabo_valid && (fsabo_mode == blit_pkg::FSAB_WRITE)) begin
				if (mon_beat == 0)
					started = started + 1;
				mon_beat = (mon_beat + 1) % `BLIT_BURST_WORDS;
			end
			if (started - returned > `BLIT_FSAB_CREDITS)
				report_error($sformatf("%0d bursts outstanding, more than the credits",
				                       started - returned));
		end
	end

	// Every request carries this block's IDs and a full burst length
	always @(posedge fsabi_clk) begin
		if (fsabi_rst_b && fsabo_valid) begin
			compare("fsabo_did", `BLIT_FSAB_DID, fsabo_did);
			compare("fsabo_subdid", `BLIT_FSAB_SUBDID, fsabo_subdid);
			compare("fsabo_len", `BLIT_BURST_WORDS, fsabo_len);
		end
	end

	function automatic logic [`BLIT_MASK_W-1:0] expected_mask(input logic [63:0] word);
		logic [`BLIT_MASK_W-1:0] mask;
		mask = '0;
		if (word[0])
			mask[3:0] = 4'hF;
		if (word[32])
			mask[7:4] = 4'hF;
		return mask;
	endfunction

	task automatic fill_memory();
		logic [63:0] word;
		int i;
		for (i = 0; i < MEM_WORDS; i++) begin
			word = {$random(seed), $random(seed)};
			// Some halves made transparent
			if (i % 3 == 1)
				word[0] = 1'b0;
			if (i % 5 == 2)
				word[32] = 1'b0;
			ref_mem[i] = word;
			u_mem.mem[i] = word;
		end
	endtask

	task automatic spam_access(input logic r_nw, input blit_pkg::blit_reg_t sel,
	                           input logic [31:0] wdata, output logic [31:0] rdata);
		int n;
		@(posedge cclk);
		spamo_valid <= 1'b1;
		spamo_r_nw <= r_nw;
		spamo_did <= `BLIT_SPAM_DID;
		spamo_addr <= `BLIT_SPAM_PFX | `BLIT_SPAM_ADDR_W'(sel);
		spamo_data <= wdata;
		n = 0;
		rdata = '0;
		@(posedge cclk);
		while (!spami_busy_b && n < 100) begin
			@(posedge cclk);
			n++;
		end
		if (spami_busy_b)
			rdata = spami_data;
		else
			report_error("SPAM access got no busy_b response");
		spamo_valid <= 1'b0;
	endtask

	task automatic spam_write(input blit_pkg::blit_reg_t sel, input logic [31:0] value);
		logic [31:0] discard;
		spam_access(1'b0, sel, value, discard);
	endtask

	task automatic spam_read(input blit_pkg::blit_reg_t sel, output logic [31:0] value);
		spam_access(1'b1, sel, 32'h0, value);
	endtask

	task automatic wait_beats(input int total);
		int n;
		n = 0;
		while (u_mem.log_cnt < total && n < WAIT_LIMIT) begin
			@(posedge fsabi_clk);
			n++;
		end
		if (u_mem.log_cnt != total)
			report_error($sformatf("wrong number of write beats, expected %0d and logged %0d",
			                       total, u_mem.log_cnt));
	endtask

	task automatic run_copy(input int src, input int dst, input int rowl, input int stride,
	                        input int bursts);
		spam_write(blit_pkg::REG_RDADDR, src);
		spam_write(blit_pkg::REG_WRADDR, dst);
		spam_write(blit_pkg::REG_WRROWL, rowl);
		spam_write(blit_pkg::REG_WRROWS, stride);
		spam_write(blit_pkg::REG_RDLEN, bursts);
	endtask

	// Burst k lands at dst + (k / rowl) * stride + (k % rowl) * 64
	task automatic check_copy(input int first, input int src, input int dst, input int rowl,
	                          input int stride, input int bursts);
		logic [`BLIT_ADDR_W-1:0] exp_addr;
		logic [63:0]             word;
		int                      k;
		int                      j;
		int                      b;
		for (k = 0; k < bursts; k++) begin
			exp_addr = dst + (k / rowl) * stride + (k % rowl) * 64;
			for (j = 0; j < `BLIT_BURST_WORDS; j++) begin
				b = first + k * `BLIT_BURST_WORDS + j;
				word = ref_mem[((src >> 3) + k * `BLIT_BURST_WORDS + j) % MEM_WORDS];
				compare("fsabo_addr", exp_addr, u_mem.log_addr[b]);
				compare("fsabo_data", word, u_mem.log_data[b]);
				compare("fsabo_mask", expected_mask(word), u_mem.log_mask[b]);
			end
		end
	endtask

	task automatic idle_after_reset();
		logic [31:0] value;
		repeat (20) begin
			@(posedge cclk);
			compare("spami_busy_b", 0, spami_busy_b);
			compare("fsabo_valid", 0, fsabo_valid);
		end
		spam_read(blit_pkg::REG_WRDONE, value);
		compare("wr_done_count", 0, value);
	endtask

	task automatic single_row_copy();
		logic [31:0] value;
		int          base;
		base = u_mem.log_cnt;
		run_copy(32'h400, 32'h8000, 3, 32'h1000, 3);
		wait_beats(base + 3 * `BLIT_BURST_WORDS);
		check_copy(base, 32'h400, 32'h8000, 3, 32'h1000, 3);
		spam_read(blit_pkg::REG_WRDONE, value);
		compare("wr_done_count", 3, value);
	endtask

	task automatic strided_copy();
		logic [31:0] value;
		int          base;
		base = u_mem.log_cnt;
		run_copy(32'h800, 32'h10000, 2, 32'h400, 6);
		wait_beats(base + 6 * `BLIT_BURST_WORDS);
		check_copy(base, 32'h800, 32'h10000, 2, 32'h400, 6);
		spam_read(blit_pkg::REG_WRDONE, value);
		compare("wr_done_count", 6, value);
	endtask

	task automatic credit_backpressure();
		logic [31:0] value;
		int          base;
		int          n;
		base = u_mem.log_cnt;
		@(posedge fsabi_clk);
		mem_hold <= 1'b1;
		run_copy(32'h1000, 32'h20000, 4, 32'h200, 8);
		n = 0;
		while (u_mem.owed < `BLIT_FSAB_CREDITS && n < WAIT_LIMIT) begin
			@(posedge fsabi_clk);
			n++;
		end
		compare("u_mem.owed", `BLIT_FSAB_CREDITS, u_mem.owed);
		// Engine must sit idle with every credit held
		repeat (30) begin
			@(posedge fsabi_clk);
			compare("fsabo_valid", 0, fsabo_valid);
		end
		compare("u_mem.log_cnt", base + 2 * `BLIT_BURST_WORDS, u_mem.log_cnt);
		mem_hold <= 1'b0;
		wait_beats(base + 8 * `BLIT_BURST_WORDS);
		check_copy(base, 32'h1000, 32'h20000, 4, 32'h200, 8);
		spam_read(blit_pkg::REG_WRDONE, value);
		compare("wr_done_count", 8, value);
	endtask

	task automatic done_count_restart();
		logic [31:0] value;
		int          base;
		base = u_mem.log_cnt;
		spam_write(blit_pkg::REG_WRDONE, 0);
		spam_write(blit_pkg::REG_RDADDR, 32'h1800);
		spam_write(blit_pkg::REG_RDLEN, 2);
		wait_beats(base + 2 * `BLIT_BURST_WORDS);
		check_copy(base, 32'h1800, 32'h20000, 4, 32'h200, 2);
		spam_read(blit_pkg::REG_WRDONE, value);
		compare("wr_done_count", 2, value);
	endtask

	initial begin
		fsabi_rst_b = 1'b0;
		cclk_rst_b = 1'b0;
		spamo_valid = 1'b0;
		spamo_r_nw = 1'b0;
		spamo_did = '0;
		spamo_addr = '0;
		spamo_data = '0;
		mem_hold = 1'b0;
		seed = 32'h224c_5670;
		fill_memory();
		fork
			begin
				repeat (4) @(posedge fsabi_clk);
				fsabi_rst_b <= 1'b1;
			end
			begin
				repeat (4) @(posedge cclk);
				cclk_rst_b <= 1'b1;
			end
		join
		idle_after_reset();
		single_row_copy();
		strided_copy();
		credit_backpressure();
		done_count_restart();
		repeat (10) @(posedge fsabi_clk);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+hw
hw/blit_pkg.sv
hw/csr_async_write.sv
hw/csr_async_read.sv
hw/blit_csr.sv
hw/blit_engine.sv
hw/accel_blit.sv
verif/fsab_mem_model.sv
verif/tb_accel_blit.sv
